// File: common/redmule_defs.svh
// ********************
// RedMulE parameters
// Array size, element width, reduction length and FIFO depth
// ********************

`ifndef REDMULE_DEFS_SVH
`define REDMULE_DEFS_SVH

// Array rows, the length of one X column
`define REDMULE_ROWS 4

// Array columns, the length of one W or Z row
`define REDMULE_COLS 4

// Bits per element
`define REDMULE_ELEM_W 16

// Longest reduction a single job may request
`define REDMULE_K_MAX 16

`define REDMULE_FIFO_DEPTH 4

`endif

// File: common/redmule_pkg.sv
// ********************
// RedMulE types
// Element, row, length and index types plus FSM and opcode enums
// ********************

`default_nettype none

package redmule_pkg;

  `include "redmule_defs.svh"

  typedef logic [`REDMULE_ELEM_W-1:0] elem_t;

  // Element r of an X column sits at index r
  typedef logic [`REDMULE_ROWS-1:0][`REDMULE_ELEM_W-1:0] x_col_t;
  typedef logic [`REDMULE_COLS-1:0][`REDMULE_ELEM_W-1:0] w_row_t;
  typedef logic [`REDMULE_COLS-1:0][`REDMULE_ELEM_W-1:0] z_row_t;

  typedef logic [$clog2(`REDMULE_K_MAX+1)-1:0] k_len_t;
  typedef logic [$clog2(`REDMULE_ROWS)-1:0]    row_idx_t;

  typedef enum logic [0:0] {
    OP_MADD,
    OP_MSUB
  } redmule_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD_Y,
    ST_COMPUTE,
    ST_STORE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/redmule_stream_fifo.sv
// ********************
// Operand stream FIFO
// Circular buffer with valid/ready on both sides
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_stream_fifo #(
  parameter int unsigned DEPTH = `REDMULE_FIFO_DEPTH,
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign do_push      = push_valid_i && push_ready_o;
  assign do_pop       = pop_i && pop_valid_o;

  // Head word goes straight out, no output register
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: redmule_ctrl/redmule_ctrl.sv
// ********************
// RedMulE controller
// Job FSM: bias load, compute, tile store
// Drives engine and Z buffer strobes plus busy
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  redmule_pkg::k_len_t      k_len_i,
  input  redmule_pkg::redmule_op_e op_i,
  input  logic                     y_valid_i,
  output logic                     y_ready_o,
  input  logic                     fifo_valid_i,
  output logic                     fifo_pop_o,
  output logic                     bias_load_o,
  output redmule_pkg::row_idx_t    bias_row_o,
  output logic                     mac_en_o,
  output redmule_pkg::redmule_op_e op_o,
  input  logic                     z_full_i,
  output logic                     store_o,
  output logic                     busy_o
);

  import redmule_pkg::*;

  localparam int unsigned ROWS = `REDMULE_ROWS;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  k_len_t      k_len_q;
  k_len_t      k_cnt_q;
  redmule_op_e op_q;
  row_idx_t    row_cnt_q;
  logic        start_ok;
  logic        y_take;
  logic        pair_take;
  logic        row_last;
  logic        k_last;

  // Start is only honoured between jobs
  assign start_ok  = start_i && (state_q == ST_IDLE);
  assign y_ready_o = (state_q == ST_LOAD_Y);
  assign y_take    = y_valid_i && y_ready_o;
  assign pair_take = (state_q == ST_COMPUTE) && fifo_valid_i;
  assign row_last  = (row_cnt_q == row_idx_t'(ROWS - 1));
  assign k_last    = (k_cnt_q == k_len_q - k_len_t'(1));

  assign bias_load_o = y_take;
  assign bias_row_o  = row_cnt_q;
  assign fifo_pop_o  = pair_take;
  assign mac_en_o    = pair_take;
  assign op_o        = op_q;
  assign store_o     = (state_q == ST_STORE) && !z_full_i;

  // Still busy while the previous tile drains out of the Z buffer
  assign busy_o = (state_q != ST_IDLE) || z_full_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_ok) begin
          state_d = ST_LOAD_Y;
        end
      end
      ST_LOAD_Y: begin
        if (y_take && row_last) begin
          state_d = ST_COMPUTE;
        end
      end
      ST_COMPUTE: begin
        if (pair_take && k_last) begin
          state_d = ST_STORE;
        end
      end
      ST_STORE: begin
        // Wait for the Z buffer to free up
        if (!z_full_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Job parameters and progress counters
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      k_len_q   <= '0;
      op_q      <= OP_MADD;
      row_cnt_q <= '0;
      k_cnt_q   <= '0;
    end else begin
      if (start_ok) begin
        k_len_q   <= k_len_i;
        op_q      <= op_i;
        row_cnt_q <= '0;
        k_cnt_q   <= '0;
      end
      if (y_take) begin
        row_cnt_q <= row_last ? '0 : row_cnt_q + 1'b1;
      end
      if (pair_take) begin
        k_cnt_q <= k_last ? '0 : k_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: redmule_engine/redmule_engine.sv
// ********************
// RedMulE engine
// ROWS x COLS integer MAC array with Y bias preload
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_engine (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                                        bias_load_i,
  input  redmule_pkg::row_idx_t                       bias_row_i,
  input  redmule_pkg::z_row_t                         y_row_i,
  input  logic                                        mac_en_i,
  input  redmule_pkg::redmule_op_e                    op_i,
  input  redmule_pkg::x_col_t                         x_col_i,
  input  redmule_pkg::w_row_t                         w_row_i,
  output redmule_pkg::z_row_t [`REDMULE_ROWS-1:0]     acc_o
);

  import redmule_pkg::*;

  localparam int unsigned ROWS = `REDMULE_ROWS;
  localparam int unsigned COLS = `REDMULE_COLS;

  z_row_t [ROWS-1:0] acc_q;

  assign acc_o = acc_q;

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    logic row_sel;

    // Only the addressed row takes the bias
    assign row_sel = bias_load_i && (bias_row_i == row_idx_t'(r));

    for (genvar c = 0; c < COLS; c++) begin : g_col
      elem_t prod;

      // Product is kept modulo 2^ELEM_W
      assign prod = x_col_i[r] * w_row_i[c];

      always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
          acc_q[r][c] <= '0;
        end else if (row_sel) begin
          acc_q[r][c] <= y_row_i[c];
        end else if (mac_en_i) begin
          if (op_i == OP_MSUB) begin
            acc_q[r][c] <= acc_q[r][c] - prod;
          end else begin
            acc_q[r][c] <= acc_q[r][c] + prod;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/redmule_z_buffer.sv
// ********************
// RedMulE Z buffer
// Captures a finished tile and drains it row by row
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_z_buffer (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    store_i,
  input  redmule_pkg::z_row_t [`REDMULE_ROWS-1:0] acc_i,
  input  logic                                    z_ready_i,
  output logic                                    z_valid_o,
  output redmule_pkg::z_row_t                     z_row_o,
  output logic                                    z_full_o,
  output logic                                    done_o
);

  import redmule_pkg::*;

  localparam int unsigned ROWS = `REDMULE_ROWS;

  z_row_t [ROWS-1:0] tile_q;
  row_idx_t          rd_row_q;
  logic              full_q;
  logic              done_q;
  logic              xfer;
  logic              last_row;

  assign xfer     = full_q && z_ready_i;
  assign last_row = (rd_row_q == row_idx_t'(ROWS - 1));

  assign z_valid_o = full_q;
  assign z_row_o   = tile_q[rd_row_q];
  assign z_full_o  = full_q;
  assign done_o    = done_q;

  // Tile payload, only written on store
  always_ff @(posedge clk_i) begin
    if (store_i) begin
      tile_q <= acc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q   <= 1'b0;
      rd_row_q <= '0;
      done_q   <= 1'b0;
    end else begin
      // One cycle pulse after the last row has left
      done_q <= xfer && last_row;
      if (store_i) begin
        full_q   <= 1'b1;
        rd_row_q <= '0;
      end else if (xfer) begin
        if (last_row) begin
          full_q   <= 1'b0;
          rd_row_q <= '0;
        end else begin
          rd_row_q <= rd_row_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/redmule_top.sv
// ********************
// RedMulE top level
// Integer Z = X*W + Y or Z = Y - X*W on a small array
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  redmule_pkg::k_len_t      k_len_i,
  input  redmule_pkg::redmule_op_e op_i,
  input  logic                     y_valid_i,
  input  redmule_pkg::z_row_t      y_row_i,
  output logic                     y_ready_o,
  input  logic                     xw_valid_i,
  input  redmule_pkg::x_col_t      x_col_i,
  input  redmule_pkg::w_row_t      w_row_i,
  output logic                     xw_ready_o,
  output logic                     z_valid_o,
  output redmule_pkg::z_row_t      z_row_o,
  input  logic                     z_ready_i,
  output logic                     busy_o,
  output logic                     done_o
);

  import redmule_pkg::*;

  localparam int unsigned ROWS   = `REDMULE_ROWS;
  localparam int unsigned X_W    = $bits(x_col_t);
  localparam int unsigned W_W    = $bits(w_row_t);
  localparam int unsigned PAIR_W = X_W + W_W;

  logic              fifo_valid;
  logic              fifo_pop;
  logic [PAIR_W-1:0] fifo_data;
  x_col_t            fifo_x;
  w_row_t            fifo_w;
  logic              bias_load;
  row_idx_t          bias_row;
  logic              mac_en;
  redmule_op_e       op;
  logic              store;
  logic              z_full;
  z_row_t [ROWS-1:0] acc;

  // X column in the upper bits, W row below
  assign {fifo_x, fifo_w} = fifo_data;

  redmule_stream_fifo #(
    .DEPTH        ( `REDMULE_FIFO_DEPTH  ),
    .WIDTH        ( PAIR_W               )
  ) u_xw_fifo (
    .clk_i        ( clk_i                ),
    .rst_n_i      ( rst_n_i              ),
    .push_valid_i ( xw_valid_i           ),
    .push_data_i  ( {x_col_i, w_row_i}   ),
    .push_ready_o ( xw_ready_o           ),
    .pop_valid_o  ( fifo_valid           ),
    .pop_data_o   ( fifo_data            ),
    .pop_i        ( fifo_pop             )
  );

  redmule_ctrl u_ctrl (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .start_i      ( start_i    ),
    .k_len_i      ( k_len_i    ),
    .op_i         ( op_i       ),
    .y_valid_i    ( y_valid_i  ),
    .y_ready_o    ( y_ready_o  ),
    .fifo_valid_i ( fifo_valid ),
    .fifo_pop_o   ( fifo_pop   ),
    .bias_load_o  ( bias_load  ),
    .bias_row_o   ( bias_row   ),
    .mac_en_o     ( mac_en     ),
    .op_o         ( op         ),
    .z_full_i     ( z_full     ),
    .store_o      ( store      ),
    .busy_o       ( busy_o     )
  );

  redmule_engine u_engine (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .bias_load_i ( bias_load ),
    .bias_row_i  ( bias_row  ),
    .y_row_i     ( y_row_i   ),
    .mac_en_i    ( mac_en    ),
    .op_i        ( op        ),
    .x_col_i     ( fifo_x    ),
    .w_row_i     ( fifo_w    ),
    .acc_o       ( acc       )
  );

  redmule_z_buffer u_z_buffer (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .store_i   ( store     ),
    .acc_i     ( acc       ),
    .z_ready_i ( z_ready_i ),
    .z_valid_o ( z_valid_o ),
    .z_row_o   ( z_row_o   ),
    .z_full_o  ( z_full    ),
    .done_o    ( done_o    )
  );

endmodule

`default_nettype wire

// File: tb/redmule_properties.sv
// ********************
// RedMulE properties
// Z stream and status checks bound to the top level
// ********************

`default_nettype none

module redmule_properties (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                z_valid_i,
  input logic                z_ready_i,
  input redmule_pkg::z_row_t z_row_i,
  input logic                done_i,
  input logic                busy_i
);

  // A stalled Z row keeps its value
  z_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_i && !z_ready_i) |=> (z_valid_i && $stable(z_row_i)))
    else $error("Z row changed while the sink was stalling");

  done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> !done_i)
    else $error("done_o was high on two cycles in a row");

  // Busy only drops together with the done pulse of the last tile
  busy_until_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(busy_i) |-> done_i)
    else $error("busy_o fell without a done_o pulse");

  // Reset leaves the output side quiet
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> (!z_valid_i && !done_i))
    else $error("Z valid or done is set right after reset");

endmodule

bind redmule_top redmule_properties u_properties (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .z_valid_i ( z_valid_o ),
  .z_ready_i ( z_ready_i ),
  .z_row_i   ( z_row_o   ),
  .done_i    ( done_o    ),
  .busy_i    ( busy_o    )
);

`default_nettype wire

// File: tb/redmule_tb.sv
// ********************
// RedMulE testbench
// Random jobs against a reference model, Z rows checked in order
// ********************

`default_nettype none

`include "redmule_defs.svh"

module redmule_tb;

  import redmule_pkg::*;

  localparam int ROWS     = `REDMULE_ROWS;
  localparam int COLS     = `REDMULE_COLS;
  localparam int ELEM_W   = `REDMULE_ELEM_W;
  localparam int K_MAX    = `REDMULE_K_MAX;
  localparam int JOBS     = 14;
  localparam int WATCHDOG = JOBS * (ROWS + K_MAX + ROWS) * 20 + 1000;
  localparam logic [31:0] LFSR_SEED = 32'd99880;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef z_row_t [ROWS-1:0] tile_t;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        start_i;
  k_len_t      k_len_i;
  redmule_op_e op_i;
  logic        y_valid_i;
  z_row_t      y_row_i;
  logic        y_ready_o;
  logic        xw_valid_i;
  x_col_t      x_col_i;
  w_row_t      w_row_i;
  logic        xw_ready_o;
  logic        z_valid_o;
  z_row_t      z_row_o;
  logic        z_ready_i;
  logic        busy_o;
  logic        done_o;

  // Stream 0 feeds job data and gaps, stream 1 the Z sink
  logic [31:0] lfsr_state [2];
  x_col_t      job_x [K_MAX];
  w_row_t      job_w [K_MAX];
  tile_t       job_y;
  tile_t       exp_q [$];
  int          jobs_started = 0;
  int          tiles_seen = 0;
  int          done_cnt = 0;
  logic        ready_random = 1'b0;
  logic        saw_full = 1'b0;

  redmule_top u_dut (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .start_i    ( start_i    ),
    .k_len_i    ( k_len_i    ),
    .op_i       ( op_i       ),
    .y_valid_i  ( y_valid_i  ),
    .y_row_i    ( y_row_i    ),
    .y_ready_o  ( y_ready_o  ),
    .xw_valid_i ( xw_valid_i ),
    .x_col_i    ( x_col_i    ),
    .w_row_i    ( w_row_i    ),
    .xw_ready_o ( xw_ready_o ),
    .z_valid_o  ( z_valid_o  ),
    .z_row_o    ( z_row_o    ),
    .z_ready_i  ( z_ready_i  ),
    .busy_o     ( busy_o     ),
    .done_o     ( done_o     )
  );

  always #4 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int src, input int n);
    logic [31:0] s;
    logic [31:0] val;
    logic        b;
    s   = lfsr_state[src];
    val = '0;
    for (int i = 0; i < n; i++) begin
      b = s[0];
      s = s >> 1;
      if (b) begin
        s = s ^ LFSR_TAPS;
      end
      val = {val[30:0], b};
    end
    lfsr_state[src] = s;
    return val;
  endfunction

  // Z = Y +/- sum over k of X[:,k] * W[k,:], all modulo 2^ELEM_W
  function automatic tile_t expected_tile(input tile_t y, input x_col_t xs [K_MAX],
                                          input w_row_t ws [K_MAX], input int k_len,
                                          input redmule_op_e op);
    tile_t               acc;
    logic [2*ELEM_W-1:0] xa;
    logic [2*ELEM_W-1:0] wb;
    logic [2*ELEM_W-1:0] prod;
    acc = y;
    for (int k = 0; k < k_len; k++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          xa   = {{ELEM_W{1'b0}}, xs[k][r]};
          wb   = {{ELEM_W{1'b0}}, ws[k][c]};
          prod = xa * wb;
          if (op == OP_MSUB) begin
            acc[r][c] = acc[r][c] - prod[ELEM_W-1:0];
          end else begin
            acc[r][c] = acc[r][c] + prod[ELEM_W-1:0];
          end
        end
      end
    end
    return acc;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic drive_y_rows();
    int row;
    row = 0;
    y_valid_i <= 1'b1;
    y_row_i   <= job_y[0];
    while (row < ROWS) begin
      @(posedge clk_i);
      if (y_valid_i && y_ready_o) begin
        row++;
        if (row < ROWS) begin
          y_row_i <= job_y[row];
        end else begin
          y_valid_i <= 1'b0;
        end
      end
    end
  endtask

  task automatic push_pairs(input int k_len, input logic gaps);
    int idx;
    idx = 0;
    while (idx < k_len) begin
      // About one idle cycle in four when gaps are on
      if (gaps && lfsr_bits(0, 2) == 32'd0) begin
        xw_valid_i <= 1'b0;
      end else begin
        xw_valid_i <= 1'b1;
      end
      x_col_i <= job_x[idx];
      w_row_i <= job_w[idx];
      @(posedge clk_i);
      if (xw_valid_i && !xw_ready_o) begin
        saw_full = 1'b1;
      end
      if (xw_valid_i && xw_ready_o) begin
        idx++;
      end
    end
    xw_valid_i <= 1'b0;
  endtask

  task automatic run_job(input int k_len, input redmule_op_e op, input logic gaps);
    for (int k = 0; k < k_len; k++) begin
      for (int r = 0; r < ROWS; r++) begin
        job_x[k][r] = elem_t'(lfsr_bits(0, ELEM_W));
      end
      for (int c = 0; c < COLS; c++) begin
        job_w[k][c] = elem_t'(lfsr_bits(0, ELEM_W));
      end
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        job_y[r][c] = elem_t'(lfsr_bits(0, ELEM_W));
      end
    end
    exp_q.push_back(expected_tile(job_y, job_x, job_w, k_len, op));
    jobs_started++;
    @(posedge clk_i);
    start_i <= 1'b1;
    k_len_i <= k_len_t'(k_len);
    op_i    <= op;
    // Start stays up until the controller is idle and takes it
    do begin
      @(posedge clk_i);
    end while (!y_ready_o);
    start_i <= 1'b0;
    fork
      drive_y_rows();
      push_pairs(k_len, gaps);
    join
  endtask

  task automatic check_drained();
    while (tiles_seen < jobs_started) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    assert (done_cnt == jobs_started)
      else stop_on_error($sformatf("done_o pulsed %0d times for %0d jobs",
                                   done_cnt, jobs_started));
    assert (!busy_o) else stop_on_error("busy_o is still high after the last tile");
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && done_o) begin
      done_cnt <= done_cnt + 1;
    end
  end

  initial begin : compare_z
    int     row;
    z_row_t want;
    row = 0;
    forever begin
      @(posedge clk_i);
      if (z_valid_o && z_ready_i) begin
        assert (exp_q.size() > 0)
          else stop_on_error("A Z row came out while no job was pending");
        want = exp_q[0][row];
        assert (z_row_o == want)
          else stop_on_error($sformatf("mismatch at %0t: tile %0d row %0d is %h, expected %h",
                                       $time, tiles_seen, row, z_row_o, want));
        row++;
        if (row == ROWS) begin
          row = 0;
          void'(exp_q.pop_front());
          tiles_seen++;
        end
      end
      // Sink takes about three rows in four when random
      if (ready_random) begin
        z_ready_i <= (lfsr_bits(1, 2) != 32'd0);
      end else begin
        z_ready_i <= 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk_i);
    stop_on_error($sformatf("Timeout, the run did not finish within %0d cycles", WATCHDOG));
  end

  initial begin : main_seq
    logic [31:0] bits;
    int          k;
    lfsr_state[0] = LFSR_SEED;
    lfsr_state[1] = LFSR_SEED;
    rst_n_i    = 1'b0;
    start_i    = 1'b0;
    k_len_i    = '0;
    op_i       = OP_MADD;
    y_valid_i  = 1'b0;
    y_row_i    = '0;
    xw_valid_i = 1'b0;
    x_col_i    = '0;
    w_row_i    = '0;
    z_ready_i  = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!y_ready_o && !z_valid_o && !done_o && !busy_o && xw_ready_o)
      else stop_on_error("Outputs are not at their idle values after reset");

    // Single step MADD with the sink always ready
    run_job(1, OP_MADD, 1'b0);
    check_drained();

    // Full length MSUB, the sums wrap around
    run_job(K_MAX, OP_MSUB, 1'b0);
    check_drained();

    ready_random = 1'b1;
    k = int'(lfsr_bits(0, 8)) % K_MAX + 1;
    run_job(k, OP_MADD, 1'b1);
    check_drained();

    // Pairs every cycle, the FIFO has to fill during the Y load
    saw_full = 1'b0;
    run_job(K_MAX, OP_MADD, 1'b0);
    check_drained();
    assert (saw_full) else stop_on_error("xw_ready_o never went low while pairs were pushed");

    for (int j = 0; j < 10; j++) begin
      k    = int'(lfsr_bits(0, 8)) % K_MAX + 1;
      bits = lfsr_bits(0, 2);
      run_job(k, bits[0] ? OP_MSUB : OP_MADD, bits[1]);
    end
    check_drained();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: redmule_top.f
+incdir+common
common/redmule_pkg.sv
source/redmule_stream_fifo.sv
redmule_ctrl/redmule_ctrl.sv
redmule_engine/redmule_engine.sv
source/redmule_z_buffer.sv
source/redmule_top.sv
tb/redmule_properties.sv
tb/redmule_tb.sv

// File: Makefile
# RedMulE simulation with Verilator

VERILATOR  ?= verilator
TOP        := redmule_tb
RTL_TOP    := redmule_top
FILELIST   := redmule_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --assert -Wno-fatal
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
